/* Bender.yml */
package:
  name: snes_pocket_glue

sources:
  - snes_pocket_pkg.sv
  - settings_if.sv
  - host_settings_regs.sv
  - clock_mode_reset_ctrl.sv
  - video_output_formatter.sv
  - snes_pocket_top.sv
  - target: test
    files:
      - tb_snes_checker.sv
      - tb_snes_pocket.sv

/* clock_mode_reset_ctrl.sv */
// PAL/NTSC clock-mode sequencer and core reset generation.
// A PAL change runs the PLL-management write sequence, waits for the
// reconfig to finish and pulses the PLL reset. The core reset covers host
// reset requests and every PLL transition.

`timescale 1ns/1ps

module clock_mode_reset_ctrl (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  settings_if.ctrl                      settings,
  input  logic                          cfg_waitrequest,
  output logic                          cfg_write,
  output snes_pocket_pkg::cfg_addr_t    cfg_address,
  output snes_pocket_pkg::bridge_data_t cfg_data,
  output logic                          pll_reset,
  output logic                          core_reset
);

  import snes_pocket_pkg::*;

  pll_seq_state_t              state;
  pll_seq_state_t              seq_next;
  cfg_addr_t                   seq_addr;
  logic                        gap;
  logic                        pal_meta;
  logic                        pal_sync;
  logic [pll_hold_cnt_w-1:0]   pll_cnt;
  logic [reset_hold_cnt_w-1:0] hold_cnt;

  // every management write carries data 0
  assign cfg_data = '0;

  // register and successor of each write state
  always_comb begin
    seq_addr = pll_mode_addr;
    seq_next = seq_mif;
    case (state)
      seq_mif: begin
        seq_addr = pll_mif_addr;
        seq_next = seq_start;
      end
      seq_start: begin
        seq_addr = pll_start_addr;
        seq_next = seq_wait;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // PLL reconfig sequencer
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_meta    <= 1'b0;
      pal_sync    <= 1'b0;
      state       <= seq_idle;
      gap         <= 1'b0;
      cfg_write   <= 1'b0;
      cfg_address <= '0;
      pll_reset   <= 1'b0;
      pll_cnt     <= '0;
    end else begin
      pal_meta  <= settings.pal;
      pal_sync  <= pal_meta;
      cfg_write <= 1'b0;

      case (state)
        seq_mode, seq_mif, seq_start: begin
          // one write, then a gap cycle
          if (!gap) begin
            cfg_write   <= 1'b1;
            cfg_address <= seq_addr;
            gap         <= 1'b1;
          end else begin
            gap   <= 1'b0;
            state <= seq_next;
          end
        end
        seq_wait: begin
          if (!cfg_waitrequest) begin
            state     <= seq_pll_reset;
            pll_reset <= 1'b1;
            pll_cnt   <= pll_hold_cnt_w'(pll_reset_hold_cycles - 1);
          end
        end
        seq_pll_reset: begin
          if (pll_cnt == '0) begin
            state     <= seq_idle;
            pll_reset <= 1'b0;
          end else begin
            pll_cnt <= pll_cnt - 1'b1;
          end
        end
        default: ;
      endcase

      // a new PAL change restarts the sequence from the top
      if (pal_sync != pal_meta) begin
        state     <= seq_mode;
        gap       <= 1'b0;
        pll_reset <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // core reset
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt   <= '0;
      core_reset <= 1'b1;
    end else begin
      if (settings.reset_request) begin
        hold_cnt <= reset_hold_cnt_w'(reset_hold_cycles - 1);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      // request cycle counts as the first hold cycle
      core_reset <= settings.reset_request || (hold_cnt != '0) ||
                    (state != seq_idle) || cfg_waitrequest || cfg_write;
    end
  end

endmodule

/* filelist.f */
snes_pocket_pkg.sv
settings_if.sv
host_settings_regs.sv
clock_mode_reset_ctrl.sv
video_output_formatter.sv
snes_pocket_top.sv
tb_snes_checker.sv
tb_snes_pocket.sv

/* host_settings_regs.sv */
// Host bridge setting registers.
// Decodes bridge writes into the cartridge, input and video settings
// and turns a write to the reset register into a one-cycle request.

`timescale 1ns/1ps

module host_settings_regs (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic                          bridge_wr,
  input  snes_pocket_pkg::bridge_addr_t bridge_addr,
  input  snes_pocket_pkg::bridge_data_t bridge_wr_data,
  settings_if.regs                      settings
);

  import snes_pocket_pkg::*;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings.rom_size           <= '0;
      settings.rom_type           <= '0;
      settings.ram_size           <= '0;
      settings.pal                <= 1'b0;
      settings.use_4_3_video      <= 1'b0;
      settings.multitap_enabled   <= 1'b0;
      settings.lightgun_enabled   <= 1'b0;
      settings.lightgun_type      <= 1'b0;
      settings.lightgun_aim_speed <= '0;
      settings.reset_request      <= 1'b0;
    end else begin
      settings.reset_request <= bridge_wr && (bridge_addr == reg_reset_addr);

      if (bridge_wr) begin
        case (bridge_addr)
          reg_rom_size_addr:  settings.rom_size <= bridge_wr_data[3:0];
          reg_rom_type_addr:  settings.rom_type <= bridge_wr_data[7:0];
          reg_ram_size_addr:  settings.ram_size <= bridge_wr_data[3:0];
          reg_pal_addr:       settings.pal      <= bridge_wr_data[0];
          reg_multitap_addr:  settings.multitap_enabled <= bridge_wr_data[0];
          reg_lightgun_addr: begin
            // enable and gun type share one word
            settings.lightgun_enabled <= bridge_wr_data[0];
            settings.lightgun_type    <= bridge_wr_data[1];
          end
          reg_aim_speed_addr: settings.lightgun_aim_speed <= bridge_wr_data[7:0];
          reg_video_mode_addr: settings.use_4_3_video <= bridge_wr_data[0];
          // unmapped, and the reset strobe above
          default: ;
        endcase
      end
    end
  end

endmodule

/* settings_if.sv */
// Host settings as seen by the rest of the glue logic.
// The register file drives every field, the other blocks read theirs.

`timescale 1ns/1ps

interface settings_if;

  logic [3:0] rom_size;
  logic [7:0] rom_type;
  logic [3:0] ram_size;
  logic       pal;
  logic       use_4_3_video;
  logic       multitap_enabled;
  logic       lightgun_enabled;
  logic       lightgun_type;
  logic [7:0] lightgun_aim_speed;
  // single-cycle strobe, all others are levels
  logic       reset_request;

  modport regs (
    output rom_size, rom_type, ram_size, pal, use_4_3_video,
    output multitap_enabled, lightgun_enabled, lightgun_type, lightgun_aim_speed,
    output reset_request
  );

  modport ctrl (input pal, reset_request);

  modport video (input pal, use_4_3_video);

  modport core (
    input rom_size, rom_type, ram_size,
    input multitap_enabled, lightgun_enabled, lightgun_type, lightgun_aim_speed
  );

endinterface

/* snes_pocket_pkg.sv */
// Shared definitions for the console top-level glue.
// Holds the host register map, the PLL-management constants, the hold
// counts and the sequencer state type. Imported by the RTL modules.

package snes_pocket_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [5:0]  cfg_addr_t;
  typedef logic [23:0] rgb_t;

  ////////////////////////////////////////////////////////////////////////////
  // host register map, one word per setting
  localparam bridge_addr_t reg_rom_size_addr   = 32'h0000_0004;
  localparam bridge_addr_t reg_rom_type_addr   = 32'h0000_0008;
  localparam bridge_addr_t reg_ram_size_addr   = 32'h0000_000C;
  localparam bridge_addr_t reg_pal_addr        = 32'h0000_0010;
  localparam bridge_addr_t reg_reset_addr      = 32'h0000_0050;
  localparam bridge_addr_t reg_multitap_addr   = 32'h0000_0100;
  localparam bridge_addr_t reg_lightgun_addr   = 32'h0000_0104;
  localparam bridge_addr_t reg_aim_speed_addr  = 32'h0000_0108;
  localparam bridge_addr_t reg_video_mode_addr = 32'h0000_0200;

  ////////////////////////////////////////////////////////////////////////////
  // hold counts in clk_74a cycles
  localparam int reset_hold_cycles     = 64;
  localparam int pll_reset_hold_cycles = 20;
  localparam int reset_hold_cnt_w      = $clog2(reset_hold_cycles);
  localparam int pll_hold_cnt_w        = $clog2(pll_reset_hold_cycles);

  // PLL reconfig registers
  localparam cfg_addr_t pll_mode_addr  = 6'd0;
  localparam cfg_addr_t pll_mif_addr   = 6'd31;
  localparam cfg_addr_t pll_start_addr = 6'd2;

  // end-of-line slot word
  localparam int slot_pal_bit    = 14;
  localparam int slot_aspect_bit = 13;

  typedef enum logic [2:0] {
    seq_idle,
    seq_mode,
    seq_mif,
    seq_start,
    seq_wait,
    seq_pll_reset
  } pll_seq_state_t;

endpackage

/* snes_pocket_top.sv */
// Host-controlled glue around the console core.
// Joins the settings register file, the clock-mode/reset sequencer and the
// video output stage. Everything runs on clk_74a.

`timescale 1ns/1ps

module snes_pocket_top (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // host bridge
  input  logic                          bridge_wr,
  input  snes_pocket_pkg::bridge_addr_t bridge_addr,
  input  snes_pocket_pkg::bridge_data_t bridge_wr_data,

  // PLL management
  input  logic                          cfg_waitrequest,
  output logic                          cfg_write,
  output snes_pocket_pkg::cfg_addr_t    cfg_address,
  output snes_pocket_pkg::bridge_data_t cfg_data,
  output logic                          pll_reset,
  output logic                          core_reset,

  // settings toward the core
  output logic [3:0]                    rom_size,
  output logic [7:0]                    rom_type,
  output logic [3:0]                    ram_size,
  output logic                          multitap_enabled,
  output logic                          lightgun_enabled,
  output logic                          lightgun_type,
  output logic [7:0]                    lightgun_aim_speed,

  // video from the core and toward the scaler
  input  logic                          h_blank,
  input  logic                          v_blank,
  input  logic                          core_hs,
  input  logic                          core_vs,
  input  snes_pocket_pkg::rgb_t         core_rgb,
  output snes_pocket_pkg::rgb_t         video_rgb,
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs
);

  settings_if settings_bus ();

  host_settings_regs i_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings_bus.regs)
  );

  clock_mode_reset_ctrl i_ctrl (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .settings       (settings_bus.ctrl),
    .cfg_waitrequest(cfg_waitrequest),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .cfg_data       (cfg_data),
    .pll_reset      (pll_reset),
    .core_reset     (core_reset)
  );

  video_output_formatter i_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .settings       (settings_bus.video),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .core_hs        (core_hs),
    .core_vs        (core_vs),
    .core_rgb       (core_rgb),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  // cartridge and input settings go straight out to the core
  assign rom_size           = settings_bus.rom_size;
  assign rom_type           = settings_bus.rom_type;
  assign ram_size           = settings_bus.ram_size;
  assign multitap_enabled   = settings_bus.multitap_enabled;
  assign lightgun_enabled   = settings_bus.lightgun_enabled;
  assign lightgun_type      = settings_bus.lightgun_type;
  assign lightgun_aim_speed = settings_bus.lightgun_aim_speed;

endmodule

/* tb_snes_checker.sv */
// Checker for the console glue testbench.
// Runs a cycle model of the register map, the reset hold, the PLL-management
// sequence and the video stage, and compares it with the DUT ports on every
// rising clock edge. Mismatches are printed and counted.

`timescale 1ns/1ps

module tb_snes_checker (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic                          bridge_wr,
  input  snes_pocket_pkg::bridge_addr_t bridge_addr,
  input  snes_pocket_pkg::bridge_data_t bridge_wr_data,
  input  logic                          cfg_waitrequest,
  input  logic                          cfg_write,
  input  snes_pocket_pkg::cfg_addr_t    cfg_address,
  input  snes_pocket_pkg::bridge_data_t cfg_data,
  input  logic                          pll_reset,
  input  logic                          core_reset,
  input  logic [3:0]                    rom_size,
  input  logic [7:0]                    rom_type,
  input  logic [3:0]                    ram_size,
  input  logic                          multitap_enabled,
  input  logic                          lightgun_enabled,
  input  logic                          lightgun_type,
  input  logic [7:0]                    lightgun_aim_speed,
  input  logic                          h_blank,
  input  logic                          v_blank,
  input  logic                          core_hs,
  input  logic                          core_vs,
  input  snes_pocket_pkg::rgb_t         core_rgb,
  input  snes_pocket_pkg::rgb_t         video_rgb,
  input  logic                          video_de,
  input  logic                          video_hs,
  input  logic                          video_vs,
  output int                            error_count,
  output int                            check_count
);

  import snes_pocket_pkg::*;

  // settings model
  logic [3:0] m_rom_size;
  logic [7:0] m_rom_type;
  logic [3:0] m_ram_size;
  logic       m_pal;
  logic       m_43;
  logic       m_multitap;
  logic       m_gun_en;
  logic       m_gun_type;
  logic [7:0] m_aim;
  logic       m_req;

  // sequencer and reset model
  // step 1..6 are the write and gap cycles, 7 the wait, 8 the PLL reset hold
  logic       m_pal_meta;
  logic       m_pal_sync;
  int         m_step;
  int         m_pll_high;
  int         m_hold;
  logic       m_cfg_write;
  cfg_addr_t  m_cfg_addr;
  logic       m_pll_reset;
  logic       m_core_reset;

  // video model
  logic       m_de;
  logic       m_hs;
  logic       m_vs;
  logic       m_hs_prev;
  logic       m_vs_prev;
  rgb_t       m_rgb;

  logic       armed;

  initial begin
    error_count = 0;
    check_count = 0;
    armed       = 1'b0;
  end

  function automatic cfg_addr_t expected_cfg_addr(input int idx);
    case (idx)
      0:       return pll_mode_addr;
      1:       return pll_mif_addr;
      default: return pll_start_addr;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: dut %0h, model %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs();
    compare("cfg_write", cfg_write, m_cfg_write);
    if (m_cfg_write) begin
      compare("cfg_address", cfg_address, m_cfg_addr);
    end
    compare("cfg_data", cfg_data, 32'h0);
    compare("pll_reset", pll_reset, m_pll_reset);
    compare("core_reset", core_reset, m_core_reset);
    compare("rom_size", rom_size, m_rom_size);
    compare("rom_type", rom_type, m_rom_type);
    compare("ram_size", ram_size, m_ram_size);
    compare("multitap_enabled", multitap_enabled, m_multitap);
    compare("lightgun_enabled", lightgun_enabled, m_gun_en);
    compare("lightgun_type", lightgun_type, m_gun_type);
    compare("lightgun_aim_speed", lightgun_aim_speed, m_aim);
    compare("video_de", video_de, m_de);
    compare("video_rgb", video_rgb, m_rgb);
    compare("video_hs", video_hs, m_hs);
    compare("video_vs", video_vs, m_vs);
  endtask

  task automatic reset_model();
    m_rom_size   = '0;
    m_rom_type   = '0;
    m_ram_size   = '0;
    m_pal        = 1'b0;
    m_43         = 1'b0;
    m_multitap   = 1'b0;
    m_gun_en     = 1'b0;
    m_gun_type   = 1'b0;
    m_aim        = '0;
    m_req        = 1'b0;
    m_pal_meta   = 1'b0;
    m_pal_sync   = 1'b0;
    m_step       = 0;
    m_pll_high   = 0;
    m_hold       = 0;
    m_cfg_write  = 1'b0;
    m_cfg_addr   = '0;
    m_pll_reset  = 1'b0;
    m_core_reset = 1'b1;
    m_de         = 1'b0;
    m_hs         = 1'b0;
    m_vs         = 1'b0;
    m_hs_prev    = 1'b0;
    m_vs_prev    = 1'b0;
    m_rgb        = '0;
  endtask

  // one clock edge, everything computed from the state before the edge
  task automatic step_model();
    logic restart;
    logic next_write;
    logic new_de;
    rgb_t slot;
    restart = (m_pal_sync != m_pal_meta);
    new_de  = ~(h_blank | v_blank);

    ////////////////////////////////////////////////////////////////////////////
    // core reset hold
    if (m_req) begin
      m_hold = reset_hold_cycles;
    end
    m_core_reset = (m_hold > 0) || (m_step != 0) || cfg_waitrequest || m_cfg_write;
    if (m_hold > 0) begin
      m_hold--;
    end

    ////////////////////////////////////////////////////////////////////////////
    // PLL-management sequence
    next_write = 1'b0;
    if (m_step >= 1 && m_step <= 6) begin
      // odd steps write, even steps are the gap cycles
      if (m_step % 2 == 1) begin
        next_write = 1'b1;
        m_cfg_addr = expected_cfg_addr(m_step / 2);
      end
      m_step++;
    end else if (m_step == 7) begin
      if (!cfg_waitrequest) begin
        m_step      = 8;
        m_pll_reset = 1'b1;
        m_pll_high  = 1;
      end
    end else if (m_step == 8) begin
      if (m_pll_high == pll_reset_hold_cycles) begin
        m_step      = 0;
        m_pll_reset = 1'b0;
      end else begin
        m_pll_high++;
      end
    end
    if (restart) begin
      m_step      = 1;
      m_pll_reset = 1'b0;
    end
    m_cfg_write = next_write;
    m_pal_sync  = m_pal_meta;
    m_pal_meta  = m_pal;

    ////////////////////////////////////////////////////////////////////////////
    // video stage
    slot                  = '0;
    slot[slot_pal_bit]    = m_pal;
    slot[slot_aspect_bit] = m_43;
    if (new_de) begin
      m_rgb = core_rgb;
    end else if (m_de) begin
      m_rgb = slot;
    end else begin
      m_rgb = '0;
    end
    m_de      = new_de;
    m_hs      = core_hs & ~m_hs_prev;
    m_vs      = core_vs & ~m_vs_prev;
    m_hs_prev = core_hs;
    m_vs_prev = core_vs;

    // register map, low bits of the write data
    m_req = bridge_wr && (bridge_addr == reg_reset_addr);
    if (bridge_wr) begin
      case (bridge_addr)
        reg_rom_size_addr:   m_rom_size = bridge_wr_data[3:0];
        reg_rom_type_addr:   m_rom_type = bridge_wr_data[7:0];
        reg_ram_size_addr:   m_ram_size = bridge_wr_data[3:0];
        reg_pal_addr:        m_pal      = bridge_wr_data[0];
        reg_multitap_addr:   m_multitap = bridge_wr_data[0];
        reg_lightgun_addr: begin
          m_gun_en   = bridge_wr_data[0];
          m_gun_type = bridge_wr_data[1];
        end
        reg_aim_speed_addr:  m_aim      = bridge_wr_data[7:0];
        reg_video_mode_addr: m_43       = bridge_wr_data[0];
        default: ;
      endcase
    end
  endtask

  always @(posedge clk_74a) begin
    if (armed) begin
      compare_outputs();
    end
    if (!pll_core_locked) begin
      reset_model();
      armed = 1'b1;
    end else begin
      step_model();
    end
  end

endmodule

/* tb_snes_pocket.sv */
// Testbench top for the console glue.
// Drives host writes, a PLL-management responder and a random video stream
// from an LFSR. tb_snes_checker does all comparing; this module runs the
// tests, prints one line per test and the final summary.

`timescale 1ns/1ps

module tb_snes_pocket;

  import snes_pocket_pkg::*;

  logic         clk_74a;
  logic         pll_core_locked;
  logic         bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  logic         cfg_waitrequest;
  logic         cfg_write;
  cfg_addr_t    cfg_address;
  bridge_data_t cfg_data;
  logic         pll_reset;
  logic         core_reset;
  logic [3:0]   rom_size;
  logic [7:0]   rom_type;
  logic [3:0]   ram_size;
  logic         multitap_enabled;
  logic         lightgun_enabled;
  logic         lightgun_type;
  logic [7:0]   lightgun_aim_speed;
  logic         h_blank;
  logic         v_blank;
  logic         core_hs;
  logic         core_vs;
  rgb_t         core_rgb;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;

  int           error_count;
  int           check_count;
  int           tests_run;
  int           tests_failed;
  int           test_timeouts;
  int           err_mark;
  int           timeout_mark;
  int           i;
  logic [15:0]  lfsr_main;
  logic [15:0]  lfsr_resp;
  logic [31:0]  rnd;
  logic [31:0]  resp_bits;

  snes_pocket_top i_dut (
    .clk_74a(clk_74a), .pll_core_locked(pll_core_locked),
    .bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .cfg_waitrequest(cfg_waitrequest), .cfg_write(cfg_write), .cfg_address(cfg_address),
    .cfg_data(cfg_data), .pll_reset(pll_reset), .core_reset(core_reset),
    .rom_size(rom_size), .rom_type(rom_type), .ram_size(ram_size),
    .multitap_enabled(multitap_enabled), .lightgun_enabled(lightgun_enabled),
    .lightgun_type(lightgun_type), .lightgun_aim_speed(lightgun_aim_speed),
    .h_blank(h_blank), .v_blank(v_blank), .core_hs(core_hs), .core_vs(core_vs),
    .core_rgb(core_rgb), .video_rgb(video_rgb), .video_de(video_de),
    .video_hs(video_hs), .video_vs(video_vs)
  );

  tb_snes_checker i_checker (
    .clk_74a(clk_74a), .pll_core_locked(pll_core_locked),
    .bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .cfg_waitrequest(cfg_waitrequest), .cfg_write(cfg_write), .cfg_address(cfg_address),
    .cfg_data(cfg_data), .pll_reset(pll_reset), .core_reset(core_reset),
    .rom_size(rom_size), .rom_type(rom_type), .ram_size(ram_size),
    .multitap_enabled(multitap_enabled), .lightgun_enabled(lightgun_enabled),
    .lightgun_type(lightgun_type), .lightgun_aim_speed(lightgun_aim_speed),
    .h_blank(h_blank), .v_blank(v_blank), .core_hs(core_hs), .core_vs(core_vs),
    .core_rgb(core_rgb), .video_rgb(video_rgb), .video_de(video_de),
    .video_hs(video_hs), .video_vs(video_vs),
    .error_count(error_count), .check_count(check_count)
  );

  initial clk_74a = 1'b0;
  always #50 clk_74a = ~clk_74a;

  // x^16 + x^14 + x^13 + x^11 + 1, shifting toward the msb
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] value);
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  function automatic bridge_addr_t reg_map(input logic [3:0] idx);
    case (idx)
      4'd0:    return reg_rom_size_addr;
      4'd1:    return reg_rom_type_addr;
      4'd2:    return reg_ram_size_addr;
      4'd3:    return reg_pal_addr;
      4'd4:    return reg_reset_addr;
      4'd5:    return reg_multitap_addr;
      4'd6:    return reg_lightgun_addr;
      4'd7:    return reg_aim_speed_addr;
      default: return reg_video_mode_addr;
    endcase
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    next_cycle();
    bridge_wr = 1'b0;
  endtask

  task automatic wait_core_reset(input logic level, input int limit);
    int n;
    n = 0;
    while (core_reset !== level && n < limit) begin
      next_cycle();
      n++;
    end
    if (core_reset !== level) begin
      $display("core_reset did not go to %0b within %0d cycles", level, limit);
      test_timeouts++;
    end
  endtask

  task automatic wait_pll_reset(input logic level, input int limit);
    int n;
    n = 0;
    while (pll_reset !== level && n < limit) begin
      next_cycle();
      n++;
    end
    if (pll_reset !== level) begin
      $display("pll_reset did not go to %0b within %0d cycles", level, limit);
      test_timeouts++;
    end
  endtask

  task automatic start_test();
    err_mark     = error_count;
    timeout_mark = test_timeouts;
  endtask

  task automatic report_test(input string name);
    int errs;
    int touts;
    errs  = error_count - err_mark;
    touts = test_timeouts - timeout_mark;
    tests_run++;
    if (errs == 0 && touts == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d mismatches, %0d timeouts", name, errs, touts);
    end
  endtask

  // PLL reconfig stays busy for 1 to 8 cycles after the start write
  always @(posedge clk_74a) begin
    if (pll_core_locked && cfg_write && cfg_address == pll_start_addr) begin
      draw_bits(lfsr_resp, 3, resp_bits);
      #1;
      cfg_waitrequest = 1'b1;
      repeat (resp_bits + 1) @(posedge clk_74a);
      #1;
      cfg_waitrequest = 1'b0;
    end
  end

  initial begin
    #1_000_000;
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    pll_core_locked = 1'b0;
    bridge_wr       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    cfg_waitrequest = 1'b0;
    h_blank         = 1'b1;
    v_blank         = 1'b1;
    core_hs         = 1'b0;
    core_vs         = 1'b0;
    core_rgb        = '0;
    lfsr_main       = 16'd16977;
    lfsr_resp       = 16'd16977;
    tests_run       = 0;
    tests_failed    = 0;
    test_timeouts   = 0;
    repeat (5) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;

    start_test();
    repeat (4) next_cycle();
    report_test("state after reset");

    ////////////////////////////////////////////////////////////////////////////
    // random writes, mapped and unmapped
    start_test();
    for (i = 0; i < 300; i++) begin
      draw_bits(lfsr_main, 4, rnd);
      if (rnd < 9) begin
        bridge_addr = reg_map(rnd[3:0]);
      end else begin
        draw_bits(lfsr_main, 10, rnd);
        bridge_addr = {20'h0, rnd[9:0], 2'b00};
      end
      draw_bits(lfsr_main, 32, rnd);
      bridge_wr_data = rnd;
      draw_bits(lfsr_main, 1, rnd);
      bridge_wr = rnd[0];
      next_cycle();
    end
    bridge_wr = 1'b0;
    // let a pending PAL change reach the sequencer
    repeat (4) next_cycle();
    wait_core_reset(1'b0, 400);
    report_test("random register writes");

    start_test();
    bus_write(reg_reset_addr, 32'h1);
    wait_core_reset(1'b1, 8);
    wait_core_reset(1'b0, reset_hold_cycles + 8);
    report_test("reset request hold");

    ////////////////////////////////////////////////////////////////////////////
    // PAL toggle from a known level
    start_test();
    bus_write(reg_pal_addr, 32'h0);
    repeat (4) next_cycle();
    wait_core_reset(1'b0, 100);
    bus_write(reg_pal_addr, 32'h1);
    wait_core_reset(1'b1, 8);
    wait_pll_reset(1'b1, 40);
    wait_pll_reset(1'b0, pll_reset_hold_cycles + 4);
    wait_core_reset(1'b0, 8);
    report_test("PAL change sequence");

    start_test();
    for (i = 0; i < 400; i++) begin
      draw_bits(lfsr_main, 2, rnd);
      h_blank = (rnd[1:0] == 2'b00);
      draw_bits(lfsr_main, 3, rnd);
      v_blank = (rnd[2:0] == 3'b000);
      draw_bits(lfsr_main, 2, rnd);
      core_hs = rnd[0];
      core_vs = rnd[1];
      draw_bits(lfsr_main, 24, rnd);
      core_rgb = rnd[23:0];
      // 4:3 and PAL bits flip every 100 cycles
      bridge_wr      = (i % 50 == 0);
      bridge_addr    = (i % 100 == 0) ? reg_video_mode_addr : reg_pal_addr;
      bridge_wr_data = bridge_data_t'((i / 100) % 2);
      next_cycle();
    end
    bridge_wr = 1'b0;
    h_blank   = 1'b1;
    v_blank   = 1'b1;
    core_hs   = 1'b0;
    core_vs   = 1'b0;
    repeat (2) next_cycle();
    report_test("video stream");

    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, timeouts %0d",
             tests_run, tests_failed, check_count, error_count, test_timeouts);
    if (tests_failed == 0 && error_count == 0 && test_timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* video_output_formatter.sv */
// Video output stage toward the scaler.
// Registers data-enable and pixels, turns core sync levels into one-cycle
// pulses and places the slot word on the first blank cycle of each line.

`timescale 1ns/1ps

module video_output_formatter (
  input  logic                  clk_74a,
  input  logic                  pll_core_locked,
  settings_if.video             settings,
  input  logic                  h_blank,
  input  logic                  v_blank,
  input  logic                  core_hs,
  input  logic                  core_vs,
  input  snes_pocket_pkg::rgb_t core_rgb,
  output snes_pocket_pkg::rgb_t video_rgb,
  output logic                  video_de,
  output logic                  video_hs,
  output logic                  video_vs
);

  import snes_pocket_pkg::*;

  logic de;
  logic de_prev;
  logic hs_prev;
  logic vs_prev;
  rgb_t slot_rgb;

  assign de = ~(h_blank | v_blank);

  // end-of-line word, carries the video mode to the scaler
  always_comb begin
    slot_rgb                  = '0;
    slot_rgb[slot_pal_bit]    = settings.pal;
    slot_rgb[slot_aspect_bit] = settings.use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de <= de;
      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // last cycle held the final pixel of the line
        video_rgb <= slot_rgb;
      end else begin
        video_rgb <= '0;
      end

      // rising edges only
      video_hs <= core_hs & ~hs_prev;
      video_vs <= core_vs & ~vs_prev;
      de_prev  <= de;
      hs_prev  <= core_hs;
      vs_prev  <= core_vs;
    end
  end

endmodule
